// File: verilog.f
+incdir+bench
source/ntt_mem_pkg.sv
source/ntt_ctrl_pkg.sv
source/ntt_arbiter.sv
source/pw_alu.sv
source/pw_engine.sv
source/poly_mem.sv
source/ntt_share_top.sv
bench/ntt_share_tb.sv

// File: Makefile
# Verilator flow for the shared polynomial engine

LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps \
		-f verilog.f --top-module ntt_share_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		-f verilog.f --top-module ntt_share_tb -o sim_ntt
	./obj_dir/sim_ntt > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/ntt_share_model.svh
`ifndef NTT_SHARE_MODEL_SVH
`define NTT_SHARE_MODEL_SVH

`default_nettype none

// Coefficient modulus
localparam longint unsigned MODEL_Q = 64'd8380417;

// Expected memory contents, kept in step with each checked command
coeff_t mirror [MEM_DEPTH];

function automatic coeff_t rand_coeff();
  return coeff_t'($urandom % MODEL_Q);
endfunction

function automatic coeff_t mod_mul(input coeff_t a, input coeff_t b);
  longint unsigned prod;
  prod = 64'(a) * 64'(b);
  return coeff_t'(prod % MODEL_Q);
endfunction

function automatic coeff_t mod_add(input coeff_t a, input coeff_t b);
  return coeff_t'((64'(a) + 64'(b)) % MODEL_Q);
endfunction

// A negative difference wraps back into range
function automatic coeff_t mod_sub(input coeff_t a, input coeff_t b);
  longint diff;
  diff = longint'(a) - longint'(b);
  if (diff < 0) begin
    diff = diff + longint'(MODEL_Q);
  end
  return coeff_t'(diff);
endfunction

function automatic logic uses_sampler(input op_mode_e mode);
  return (mode == OP_PWM_SMPL) || (mode == OP_PWM_ACC_SMPL);
endfunction

// New destination word from operands a, b and the old destination d
function automatic coeff_t model_result(input op_mode_e mode, input coeff_t a,
                                        input coeff_t b, input coeff_t d);
  case (mode)
    OP_PWM, OP_PWM_SMPL:         return mod_mul(a, b);
    OP_PWM_ACC, OP_PWM_ACC_SMPL: return mod_add(d, mod_mul(a, b));
    OP_PWA:                      return mod_add(a, b);
    OP_PWS:                      return mod_sub(a, b);
    default:                     return d;
  endcase
endfunction

`default_nettype wire

`endif

// File: bench/ntt_share_tb.sv
`default_nettype none

module ntt_share_tb
  import ntt_ctrl_pkg::*;
  import ntt_mem_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_COEFF   = 16;
  localparam int MEM_DEPTH = 256;
  localparam int TIMEOUT   = 1000;

  logic           clk = 1'b0;
  logic           reset_n;
  logic [1:0]     cmd_valid;
  logic [1:0]     cmd_ready;
  ntt_cmd_t [1:0] cmd;
  logic [1:0]     samp_valid = '0;
  coeff_t [1:0]   samp_data = '0;
  logic [1:0]     samp_ready;
  logic           host_valid;
  logic           host_ready;
  host_req_t      host_req;
  logic           host_rvalid;
  coeff_t         host_rdata;
  logic [1:0]     busy;
  logic [1:0]     done;
  logic           samp_en;
  coeff_t         samp_words [$];

  `include "ntt_share_model.svh"

  ntt_share_top #(
    .N_COEFF  (N_COEFF),
    .MEM_DEPTH(MEM_DEPTH)
  ) DUT (
    .clk          (clk),
    .reset_n      (reset_n),
    .cmd_valid_i  (cmd_valid),
    .cmd_ready_o  (cmd_ready),
    .cmd_i        (cmd),
    .samp_valid_i (samp_valid),
    .samp_data_i  (samp_data),
    .samp_ready_o (samp_ready),
    .host_valid_i (host_valid),
    .host_ready_o (host_ready),
    .host_req_i   (host_req),
    .host_rvalid_o(host_rvalid),
    .host_rdata_o (host_rdata),
    .busy_o       (busy),
    .done_o       (done)
  );

  always #4 clk = ~clk;

  // Sampler streams with random gaps on both channels
  always @(posedge clk) begin
    if (samp_en) begin
      samp_valid <= {($urandom % 3) != 0, ($urandom % 3) != 0};
      samp_data  <= {rand_coeff(), rand_coeff()};
    end else begin
      samp_valid <= 2'b00;
    end
  end

  // Log every sampler word that the DUT takes
  always @(negedge clk) begin
    if (samp_valid[0] && samp_ready[0]) begin
      samp_words.push_back(samp_data[0]);
    end
    if (samp_valid[1] && samp_ready[1]) begin
      samp_words.push_back(samp_data[1]);
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_coeff(input string name, input coeff_t actual, input coeff_t expected);
    if (actual !== expected) begin
      abort_run($sformatf("[ERROR] time %0t: %s = %0d, expected %0d",
                          $time, name, actual, expected));
    end
  endtask

  task automatic check_status(input string name, input logic [1:0] actual,
                              input logic [1:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("[ERROR] time %0t: %s = %b, expected %b",
                          $time, name, actual, expected));
    end
  endtask

  task automatic host_transfer(input logic wr, input mem_addr_t addr, input coeff_t wdata);
    int cycles;
    cycles = 0;
    @(posedge clk);
    host_valid <= 1'b1;
    host_req   <= '{write: wr, addr: addr, wdata: wdata};
    @(negedge clk);
    while (!host_ready) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("timeout waiting for host_ready_o");
      end
      @(negedge clk);
    end
    @(posedge clk);
    host_valid <= 1'b0;
  endtask

  task automatic host_read(input mem_addr_t addr, output coeff_t data);
    host_transfer(1'b0, addr, '0);
    @(negedge clk);
    if (!host_rvalid) begin
      abort_run($sformatf("host read of address %0d returned no data one cycle later", addr));
    end
    data = host_rdata;
  endtask

  // Called on a rising edge
  task automatic post_cmd(input int ch, input ntt_cmd_t c);
    cmd_valid[ch] <= 1'b1;
    cmd[ch]       <= c;
  endtask

  task automatic wait_accept(input int ch);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!cmd_ready[ch]) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run($sformatf("timeout waiting for cmd_ready_o on channel %0d", ch));
      end
      @(negedge clk);
    end
    check_status("cmd_ready_o", cmd_ready, 2'b01 << ch);
    @(posedge clk);
    cmd_valid[ch] <= 1'b0;
  endtask

  // Status, sampler and host lockout are watched every cycle of the run
  task automatic wait_done(input int ch);
    logic [1:0] owner;
    int         cycles;
    owner  = 2'b01 << ch;
    cycles = 0;
    @(negedge clk);
    while (done == 2'b00) begin
      check_status("busy_o", busy, owner);
      check_status("samp_ready_o", samp_ready & ~owner, 2'b00);
      check_status("host_ready_o", {1'b0, host_ready}, 2'b00);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run($sformatf("timeout waiting for done_o on channel %0d", ch));
      end
      @(negedge clk);
    end
    check_status("done_o", done, owner);
    check_status("busy_o", busy, owner);
  endtask

  // Regions are whole N_COEFF slots, the destination apart from both sources
  function automatic ntt_cmd_t random_cmd(input op_mode_e mode);
    ntt_cmd_t c;
    int       slots;
    int       slot_d;
    slots  = MEM_DEPTH / N_COEFF;
    slot_d = $urandom % slots;
    c.mode  = mode;
    c.dst   = mem_addr_t'(slot_d * N_COEFF);
    c.src_a = mem_addr_t'(((slot_d + 1 + $urandom % (slots - 1)) % slots) * N_COEFF);
    c.src_b = mem_addr_t'(((slot_d + 1 + $urandom % (slots - 1)) % slots) * N_COEFF);
    return c;
  endfunction

  task automatic verify_dst(input ntt_cmd_t c);
    coeff_t    a;
    coeff_t    b;
    coeff_t    want;
    coeff_t    got;
    mem_addr_t addr;
    int        k;
    if (uses_sampler(c.mode) && samp_words.size() != N_COEFF) begin
      abort_run($sformatf("engine took %0d sampler words instead of %0d",
                          samp_words.size(), N_COEFF));
    end
    for (k = 0; k < N_COEFF; k++) begin
      addr = c.dst + mem_addr_t'(k);
      a    = mirror[c.src_a + mem_addr_t'(k)];
      b    = uses_sampler(c.mode) ? samp_words[k] : mirror[c.src_b + mem_addr_t'(k)];
      want = model_result(c.mode, a, b, mirror[addr]);
      host_read(addr, got);
      check_coeff($sformatf("mem[%0d]", addr), got, want);
      mirror[addr] = want;
    end
  endtask

  task automatic run_op(input int ch, input op_mode_e mode);
    ntt_cmd_t c;
    c = random_cmd(mode);
    @(negedge clk);
    samp_en = uses_sampler(mode);
    @(posedge clk);
    samp_words.delete();
    post_cmd(ch, c);
    wait_accept(ch);
    wait_done(ch);
    samp_en = 1'b0;
    @(negedge clk);
    check_status("busy_o", busy, 2'b00);
    check_status("done_o", done, 2'b00);
    verify_dst(c);
  endtask

  initial begin
    ntt_cmd_t c0;
    ntt_cmd_t c1;
    coeff_t   got;
    int       i;

    reset_n    = 1'b0;
    cmd_valid  = '0;
    cmd        = '0;
    host_valid = 1'b0;
    host_req   = '0;
    samp_en    = 1'b0;
    void'($urandom(28));

    repeat (10) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    check_status("busy_o", busy, 2'b00);
    check_status("done_o", done, 2'b00);
    check_status("samp_ready_o", samp_ready, 2'b00);
    check_status("host_rvalid_o", {1'b0, host_rvalid}, 2'b00);
    check_status("cmd_ready_o", cmd_ready, 2'b00);

    for (i = 0; i < MEM_DEPTH; i++) begin
      mirror[i] = rand_coeff();
      host_transfer(1'b1, mem_addr_t'(i), mirror[i]);
    end

    repeat (3) begin
      for (i = 0; i < 2; i++) begin
        run_op(i, OP_PWM);
        run_op(i, OP_PWA);
        run_op(i, OP_PWS);
        run_op(i, OP_PWM_ACC);
        run_op(i, OP_PWM_SMPL);
        run_op(i, OP_PWM_ACC_SMPL);
      end
    end

    // Both channels request in the same cycle
    c0 = random_cmd(OP_PWA);
    c1 = random_cmd(OP_PWM_ACC);
    while (c1.dst == c0.dst || c1.dst == c0.src_a || c1.dst == c0.src_b) begin
      c1 = random_cmd(OP_PWM_ACC);
    end
    @(posedge clk);
    post_cmd(0, c0);
    post_cmd(1, c1);
    wait_accept(0);
    wait_done(0);
    wait_accept(1);
    wait_done(1);
    @(negedge clk);
    check_status("busy_o", busy, 2'b00);
    verify_dst(c0);
    verify_dst(c1);

    for (i = 0; i < MEM_DEPTH; i++) begin
      host_read(mem_addr_t'(i), got);
      check_coeff($sformatf("mem[%0d]", i), got, mirror[i]);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: source/ntt_share_top.sv
`default_nettype none

module ntt_share_top
  import ntt_ctrl_pkg::*;
  import ntt_mem_pkg::*;
#(
  parameter int N_COEFF   = 16,
  parameter int MEM_DEPTH = 256
) (
  input  logic           clk,
  input  logic           reset_n,
  input  logic [1:0]     cmd_valid_i,
  output logic [1:0]     cmd_ready_o,
  input  ntt_cmd_t [1:0] cmd_i,
  input  logic [1:0]     samp_valid_i,
  input  coeff_t [1:0]   samp_data_i,
  output logic [1:0]     samp_ready_o,
  input  logic           host_valid_i,
  output logic           host_ready_o,
  input  host_req_t      host_req_i,
  output logic           host_rvalid_o,
  output coeff_t         host_rdata_o,
  output logic [1:0]     busy_o,
  output logic [1:0]     done_o
);

  logic      eng_start;
  eng_ctrl_t eng_ctrl;
  logic      eng_busy;
  logic      eng_done;
  logic      eng_samp_valid;
  logic      eng_samp_ready;
  coeff_t    eng_samp_data;
  mem_req_t  rd_a;
  mem_req_t  rd_b;
  mem_req_t  rd_d;
  mem_req_t  wr;
  coeff_t    wr_data;
  coeff_t    rd_a_data;
  coeff_t    rd_b_data;
  coeff_t    rd_d_data;

  ntt_arbiter u_arbiter (
    .clk             (clk),
    .reset_n         (reset_n),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_ready_o     (cmd_ready_o),
    .cmd_i           (cmd_i),
    .samp_valid_i    (samp_valid_i),
    .samp_data_i     (samp_data_i),
    .samp_ready_o    (samp_ready_o),
    .eng_busy_i      (eng_busy),
    .eng_done_i      (eng_done),
    .eng_samp_ready_i(eng_samp_ready),
    .eng_start_o     (eng_start),
    .eng_ctrl_o      (eng_ctrl),
    .eng_samp_valid_o(eng_samp_valid),
    .eng_samp_data_o (eng_samp_data),
    .busy_o          (busy_o),
    .done_o          (done_o)
  );

  pw_engine #(
    .N_COEFF(N_COEFF)
  ) u_engine (
    .clk         (clk),
    .reset_n     (reset_n),
    .start_i     (eng_start),
    .ctrl_i      (eng_ctrl),
    .samp_valid_i(eng_samp_valid),
    .samp_data_i (eng_samp_data),
    .samp_ready_o(eng_samp_ready),
    .busy_o      (eng_busy),
    .done_o      (eng_done),
    .rd_a_o      (rd_a),
    .rd_b_o      (rd_b),
    .rd_d_o      (rd_d),
    .rd_a_data_i (rd_a_data),
    .rd_b_data_i (rd_b_data),
    .rd_d_data_i (rd_d_data),
    .wr_o        (wr),
    .wr_data_o   (wr_data)
  );

  // Lock the host from command acceptance through done
  poly_mem #(
    .MEM_DEPTH(MEM_DEPTH)
  ) u_mem (
    .clk          (clk),
    .reset_n      (reset_n),
    .eng_busy_i   (|busy_o),
    .rd_a_i       (rd_a),
    .rd_b_i       (rd_b),
    .rd_d_i       (rd_d),
    .wr_i         (wr),
    .wr_data_i    (wr_data),
    .rd_a_data_o  (rd_a_data),
    .rd_b_data_o  (rd_b_data),
    .rd_d_data_o  (rd_d_data),
    .host_valid_i (host_valid_i),
    .host_ready_o (host_ready_o),
    .host_req_i   (host_req_i),
    .host_rvalid_o(host_rvalid_o),
    .host_rdata_o (host_rdata_o)
  );

endmodule

`default_nettype wire

// File: source/poly_mem.sv
`default_nettype none

module poly_mem
  import ntt_mem_pkg::*;
#(
  parameter int MEM_DEPTH = 256
) (
  input  logic      clk,
  input  logic      reset_n,
  input  logic      eng_busy_i,
  input  mem_req_t  rd_a_i,
  input  mem_req_t  rd_b_i,
  input  mem_req_t  rd_d_i,
  input  mem_req_t  wr_i,
  input  coeff_t    wr_data_i,
  output coeff_t    rd_a_data_o,
  output coeff_t    rd_b_data_o,
  output coeff_t    rd_d_data_o,
  input  logic      host_valid_i,
  output logic      host_ready_o,
  input  host_req_t host_req_i,
  output logic      host_rvalid_o,
  output coeff_t    host_rdata_o
);

  coeff_t mem [MEM_DEPTH];
  logic   host_accept;

  // Host is locked out while a command runs
  assign host_ready_o = !eng_busy_i;
  assign host_accept  = host_valid_i && host_ready_o;

  always_ff @(posedge clk) begin
    if (rd_a_i.rd_wr == RW_READ) begin
      rd_a_data_o <= mem[rd_a_i.addr];
    end
    if (rd_b_i.rd_wr == RW_READ) begin
      rd_b_data_o <= mem[rd_b_i.addr];
    end
    if (rd_d_i.rd_wr == RW_READ) begin
      rd_d_data_o <= mem[rd_d_i.addr];
    end
    if (wr_i.rd_wr == RW_WRITE) begin
      mem[wr_i.addr] <= wr_data_i;
    end
    if (host_accept) begin
      if (host_req_i.write) begin
        mem[host_req_i.addr] <= host_req_i.wdata;
      end else begin
        host_rdata_o <= mem[host_req_i.addr];
      end
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      host_rvalid_o <= 1'b0;
    end else begin
      host_rvalid_o <= host_accept && !host_req_i.write;
    end
  end

endmodule

`default_nettype wire

// File: source/pw_engine.sv
`default_nettype none

module pw_engine
  import ntt_ctrl_pkg::*;
  import ntt_mem_pkg::*;
#(
  parameter int N_COEFF = 16
) (
  input  logic      clk,
  input  logic      reset_n,
  input  logic      start_i,
  input  eng_ctrl_t ctrl_i,
  input  logic      samp_valid_i,
  input  coeff_t    samp_data_i,
  output logic      samp_ready_o,
  output logic      busy_o,
  output logic      done_o,
  output mem_req_t  rd_a_o,
  output mem_req_t  rd_b_o,
  output mem_req_t  rd_d_o,
  input  coeff_t    rd_a_data_i,
  input  coeff_t    rd_b_data_i,
  input  coeff_t    rd_d_data_i,
  output mem_req_t  wr_o,
  output coeff_t    wr_data_o
);

  localparam int IDX_W = $clog2(N_COEFF + 1);

  logic                  busy_q;
  logic [IDX_W-1:0]      idx_q;
  logic                  issuing;
  logic                  issue;
  mem_addr_t             offset;
  // Valid per stage: read data, ALU stage 1, ALU result
  logic [2:0]            vld_q;
  mem_addr_t [2:0]       off_q;
  coeff_t                samp_q;
  coeff_t                alu_b;
  logic                  alu_valid;
  coeff_t                alu_result;

  assign offset  = mem_addr_t'(idx_q);
  assign issuing = busy_q && (idx_q < IDX_W'(N_COEFF));
  // Sampler modes wait for a sampler word
  assign issue   = issuing && (!ctrl_i.use_sampler || samp_valid_i);

  assign samp_ready_o = issuing && ctrl_i.use_sampler;
  assign busy_o       = busy_q;
  assign done_o       = busy_q && !issuing && (vld_q == 3'b000);

  always_comb begin
    rd_a_o.rd_wr = issue ? RW_READ : RW_IDLE;
    rd_a_o.addr  = ctrl_i.src_a + offset;
    rd_b_o.rd_wr = (issue && !ctrl_i.use_sampler) ? RW_READ : RW_IDLE;
    rd_b_o.addr  = ctrl_i.src_b + offset;
    // Old destination word for accumulate
    rd_d_o.rd_wr = (issue && ctrl_i.accumulate) ? RW_READ : RW_IDLE;
    rd_d_o.addr  = ctrl_i.dst + offset;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
      vld_q  <= 3'b000;
    end else begin
      vld_q <= {vld_q[1:0], issue};
      if (start_i && !busy_q) begin
        busy_q <= 1'b1;
        idx_q  <= '0;
      end else begin
        if (issue) begin
          idx_q <= idx_q + 1'b1;
        end
        if (done_o) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // Index and sampler word travel with the item
  always_ff @(posedge clk) begin
    off_q <= {off_q[1:0], offset};
    if (issue) begin
      samp_q <= samp_data_i;
    end
  end

  assign alu_b = ctrl_i.use_sampler ? samp_q : rd_b_data_i;

  pw_alu u_alu (
    .clk        (clk),
    .reset_n    (reset_n),
    .in_valid_i (vld_q[0]),
    .mode_i     (ctrl_i.eng_mode),
    .acc_i      (ctrl_i.accumulate),
    .a_i        (rd_a_data_i),
    .b_i        (alu_b),
    .d_i        (rd_d_data_i),
    .out_valid_o(alu_valid),
    .result_o   (alu_result)
  );

  assign wr_o.rd_wr = alu_valid ? RW_WRITE : RW_IDLE;
  assign wr_o.addr  = ctrl_i.dst + off_q[2];
  assign wr_data_o  = alu_result;

  a_wr_in_range: assert property (@(posedge clk) disable iff (!reset_n)
    wr_o.rd_wr == RW_WRITE |-> mem_addr_t'(wr_o.addr - ctrl_i.dst) < N_COEFF);

endmodule

`default_nettype wire

// File: source/pw_alu.sv
`default_nettype none

module pw_alu
  import ntt_ctrl_pkg::*;
  import ntt_mem_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  logic      in_valid_i,
  input  eng_mode_e mode_i,
  input  logic      acc_i,
  input  coeff_t    a_i,
  input  coeff_t    b_i,
  input  coeff_t    d_i,
  output logic      out_valid_o,
  output coeff_t    result_o
);

  logic        s1_valid_q;
  logic        s1_acc_q;
  logic [45:0] s1_val_q;
  coeff_t      s1_d_q;
  logic [45:0] s1_val;
  coeff_t      red;
  logic [23:0] acc_sum;
  coeff_t      s2_result;

  // Stage 1: raw product, sum or difference
  always_comb begin
    case (mode_i)
      ADD:     s1_val = 46'(a_i) + 46'(b_i);
      // Offset by q so the difference stays positive
      SUB:     s1_val = 46'(a_i) + 46'(Q_MOD) - 46'(b_i);
      default: s1_val = 46'(a_i) * 46'(b_i);
    endcase
  end

  // Stage 2: reduce, then optional accumulate with one conditional subtract
  assign red       = coeff_t'(s1_val_q % 46'(Q_MOD));
  assign acc_sum   = {1'b0, red} + (s1_acc_q ? {1'b0, s1_d_q} : 24'd0);
  assign s2_result = (acc_sum >= {1'b0, Q_MOD}) ? coeff_t'(acc_sum - {1'b0, Q_MOD})
                                                : acc_sum[22:0];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      s1_valid_q  <= 1'b0;
      out_valid_o <= 1'b0;
    end else begin
      s1_valid_q  <= in_valid_i;
      out_valid_o <= s1_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    s1_val_q <= s1_val;
    s1_acc_q <= acc_i;
    s1_d_q   <= d_i;
    result_o <= s2_result;
  end

  // Memory and sampler only ever hold reduced values
  a_in_reduced: assert property (@(posedge clk) disable iff (!reset_n)
    in_valid_i |-> (a_i < Q_MOD) && (b_i < Q_MOD) && (!acc_i || d_i < Q_MOD));

endmodule

`default_nettype wire

// File: source/ntt_arbiter.sv
`default_nettype none

module ntt_arbiter
  import ntt_ctrl_pkg::*;
  import ntt_mem_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic [1:0]           cmd_valid_i,
  output logic [1:0]           cmd_ready_o,
  input  ntt_cmd_t [1:0]       cmd_i,
  input  logic [1:0]           samp_valid_i,
  input  coeff_t [1:0]         samp_data_i,
  output logic [1:0]           samp_ready_o,
  input  logic                 eng_busy_i,
  input  logic                 eng_done_i,
  input  logic                 eng_samp_ready_i,
  output logic                 eng_start_o,
  output eng_ctrl_t            eng_ctrl_o,
  output logic                 eng_samp_valid_o,
  output coeff_t               eng_samp_data_o,
  output logic [1:0]           busy_o,
  output logic [1:0]           done_o
);

  logic       init_q;
  logic [1:0] owner_q;
  logic       start_q;
  ntt_cmd_t   cmd_q;
  logic       can_accept;
  logic [1:0] grant;

  // Idle engine and nobody holding it
  assign can_accept     = init_q && (owner_q == 2'b00) && !eng_busy_i;
  // Channel 0 has priority, channel 1 only when it alone is valid
  assign cmd_ready_o[0] = can_accept && (cmd_valid_i[0] || !cmd_valid_i[1]);
  assign cmd_ready_o[1] = can_accept && !cmd_valid_i[0] && cmd_valid_i[1];
  assign grant          = cmd_valid_i & cmd_ready_o;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      init_q  <= 1'b0;
      owner_q <= 2'b00;
      start_q <= 1'b0;
      cmd_q   <= '0;
    end else begin
      init_q  <= 1'b1;
      start_q <= |grant;
      if (|grant) begin
        owner_q <= grant;
        cmd_q   <= grant[0] ? cmd_i[0] : cmd_i[1];
      end else if (eng_done_i) begin
        owner_q <= 2'b00;
      end
    end
  end

  assign eng_start_o = start_q;

  // Mode decode
  always_comb begin
    eng_ctrl_o.eng_mode    = MUL;
    eng_ctrl_o.accumulate  = 1'b0;
    eng_ctrl_o.use_sampler = 1'b0;
    eng_ctrl_o.src_a       = cmd_q.src_a;
    eng_ctrl_o.src_b       = cmd_q.src_b;
    eng_ctrl_o.dst         = cmd_q.dst;
    case (cmd_q.mode)
      OP_PWM_ACC: eng_ctrl_o.accumulate = 1'b1;
      OP_PWA:     eng_ctrl_o.eng_mode = ADD;
      OP_PWS:     eng_ctrl_o.eng_mode = SUB;
      OP_PWM_SMPL: eng_ctrl_o.use_sampler = 1'b1;
      OP_PWM_ACC_SMPL: begin
        eng_ctrl_o.accumulate  = 1'b1;
        eng_ctrl_o.use_sampler = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // Only the owner's sampler reaches the engine
  assign eng_samp_valid_o = |(owner_q & samp_valid_i);
  assign eng_samp_data_o  = owner_q[1] ? samp_data_i[1] : samp_data_i[0];
  assign samp_ready_o     = owner_q & {2{eng_samp_ready_i}};

  assign busy_o = owner_q;
  assign done_o = owner_q & {2{eng_done_i}};

  a_owner_onehot: assert property (@(posedge clk) disable iff (!reset_n)
    $onehot0(owner_q));

  // Engine finishes only for a command granted earlier and still owned
  a_done_owned: assert property (@(posedge clk) disable iff (!reset_n)
    eng_done_i |-> (owner_q != 2'b00) && (owner_q == $past(owner_q)));

endmodule

`default_nettype wire

// File: source/ntt_ctrl_pkg.sv
`default_nettype none

package ntt_ctrl_pkg;

  import ntt_mem_pkg::*;

  // Operations a controller can request
  typedef enum logic [3:0] {
    OP_NONE         = 4'd0,
    OP_PWM          = 4'd1,
    OP_PWM_ACC      = 4'd2,
    OP_PWA          = 4'd3,
    OP_PWS          = 4'd4,
    OP_PWM_SMPL     = 4'd5,
    OP_PWM_ACC_SMPL = 4'd6
  } op_mode_e;

  // ALU operation
  typedef enum logic [1:0] {
    MUL = 2'd0,
    ADD = 2'd1,
    SUB = 2'd2
  } eng_mode_e;

  typedef struct packed {
    op_mode_e  mode;
    mem_addr_t src_a;
    mem_addr_t src_b;
    mem_addr_t dst;
  } ntt_cmd_t;

  // Decoded controls seen by the engine
  typedef struct packed {
    eng_mode_e eng_mode;
    logic      accumulate;
    logic      use_sampler;
    mem_addr_t src_a;
    mem_addr_t src_b;
    mem_addr_t dst;
  } eng_ctrl_t;

  localparam coeff_t Q_MOD = 23'd8380417;

endpackage

`default_nettype wire

// File: source/ntt_mem_pkg.sv
`default_nettype none

package ntt_mem_pkg;

  // One coefficient modulo q
  typedef logic [22:0] coeff_t;

  // Word address into the shared memory, depth up to 256
  typedef logic [7:0] mem_addr_t;

  typedef enum logic [1:0] {
    RW_IDLE  = 2'd0,
    RW_READ  = 2'd1,
    RW_WRITE = 2'd2
  } mem_rw_e;

  // Engine side memory request
  typedef struct packed {
    mem_rw_e   rd_wr;
    mem_addr_t addr;
  } mem_req_t;

  // Host load and readback request
  typedef struct packed {
    logic      write;
    mem_addr_t addr;
    coeff_t    wdata;
  } host_req_t;

endpackage

`default_nettype wire
